//--- logic/datapath_params.svh
// Datapath width, I/O port, address tag and pipeline depth macros
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// ------------------------------
// Data and address widths
// ------------------------------

`define DP_WORD_WIDTH       16
`define DP_READ_ADDR_WIDTH  6

// ------------------------------
// Memory-mapped I/O
// ------------------------------

// Same port count on the A and B sides
`define DP_IO_PORT_COUNT    4
`define DP_IO_PORT_BITS     2

// Upper four address bits all set, so 60 to 63 are ports and 0 to 59 memory
`define DP_IO_TAG           4'hF

// ------------------------------
// Memory and pipeline
// ------------------------------

`define DP_MEM_DEPTH        64

// Rising edges from instruction sample to write-back
`define DP_WB_LATENCY       4

`endif

//--- logic/datapath_pkg.sv
// Address union, instruction, operand and write-back structs, ALU op codes
`include "datapath_params.svh"

package datapath_pkg;

    // ------------------------------
    // ALU control
    // ------------------------------

    // Code 7 is unused and falls back to pass_a
    typedef enum logic [2:0] {
        pass_a = 3'd0,
        pass_b = 3'd1,
        add    = 3'd2,
        sub    = 3'd3,
        op_and = 3'd4,
        op_or  = 3'd5,
        op_xor = 3'd6
    } alu_op_t;

    // ------------------------------
    // Addresses
    // ------------------------------

    // Same six bits seen as a memory word index or as tag plus port number
    typedef union packed {
        logic [`DP_READ_ADDR_WIDTH-1:0] mem_index;
        struct packed {
            logic [`DP_READ_ADDR_WIDTH-`DP_IO_PORT_BITS-1:0] tag;
            logic [`DP_IO_PORT_BITS-1:0]                     port;
        } io;
    } read_addr_u;

    // Side 0 targets A, side 1 targets B
    typedef struct packed {
        logic       side;
        read_addr_u addr;
    } write_addr_t;

    typedef struct packed {
        alu_op_t     op;
        read_addr_u  addr_a;
        read_addr_u  addr_b;
        write_addr_t addr_d;
    } instr_t;

    // ------------------------------
    // Pipeline words
    // ------------------------------

    typedef struct packed {
        logic                     live;
        alu_op_t                  op;
        logic [`DP_WORD_WIDTH-1:0] a;
        logic [`DP_WORD_WIDTH-1:0] b;
        write_addr_t              addr_d;
    } operands_t;

    typedef struct packed {
        logic                     en;
        write_addr_t              addr_d;
        logic [`DP_WORD_WIDTH-1:0] data;
        logic                     carry;
    } wb_t;

endpackage

//--- logic/io_predication.sv
// Stage 1 instruction register, I/O address decode, empty/full checks and read pops
`timescale 1ns/100ps
`include "datapath_params.svh"

module io_predication (
    input  logic                          clock,
    input  logic                          rst_n,
    input  datapath_pkg::instr_t          instr,
    input  logic                          cancel,
    input  logic [`DP_IO_PORT_COUNT-1:0]  io_read_ef_a,
    input  logic [`DP_IO_PORT_COUNT-1:0]  io_read_ef_b,
    input  logic [`DP_IO_PORT_COUNT-1:0]  io_write_ef_a,
    input  logic [`DP_IO_PORT_COUNT-1:0]  io_write_ef_b,
    output datapath_pkg::instr_t          s1_instr,
    output logic                          s1_live,
    output logic                          io_ready,
    output logic [`DP_IO_PORT_COUNT-1:0]  io_rden_a,
    output logic [`DP_IO_PORT_COUNT-1:0]  io_rden_b
);

    logic                          cancel_q;
    logic                          read_io_a;
    logic                          read_io_b;
    logic                          write_io;
    logic [`DP_IO_PORT_COUNT-1:0]  write_ef;
    logic                          read_ok_a;
    logic                          read_ok_b;
    logic                          write_ok;

    // ------------------------------
    // Stage 1 register
    // ------------------------------

    // Cancel comes out of reset set so nothing is live until the first real edge
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_instr <= '0;
            cancel_q <= 1'b1;
        end else begin
            s1_instr <= instr;
            cancel_q <= cancel;
        end
    end

    // ------------------------------
    // Address decode
    // ------------------------------

    assign read_io_a = (s1_instr.addr_a.io.tag == `DP_IO_TAG);
    assign read_io_b = (s1_instr.addr_b.io.tag == `DP_IO_TAG);
    assign write_io  = (s1_instr.addr_d.addr.io.tag == `DP_IO_TAG);

    // D picks its full bits by side
    assign write_ef = s1_instr.addr_d.side ? io_write_ef_b : io_write_ef_a;

    // Memory operands are always ready
    assign read_ok_a = !read_io_a || io_read_ef_a[s1_instr.addr_a.io.port];
    assign read_ok_b = !read_io_b || io_read_ef_b[s1_instr.addr_b.io.port];
    assign write_ok  = !write_io  || write_ef[s1_instr.addr_d.addr.io.port];

    assign io_ready = read_ok_a && read_ok_b && write_ok;
    assign s1_live  = io_ready && !cancel_q;

    // ------------------------------
    // Read port pops
    // ------------------------------

    // One-hot pop per side, only for an instruction that goes ahead
    always_comb begin
        io_rden_a = '0;
        io_rden_b = '0;
        if (s1_live && read_io_a) begin
            io_rden_a[s1_instr.addr_a.io.port] = 1'b1;
        end
        if (s1_live && read_io_b) begin
            io_rden_b[s1_instr.addr_b.io.port] = 1'b1;
        end
    end

endmodule

//--- logic/data_memory.sv
// A and B data RAMs, I/O read capture, operand register and write-back decode
`timescale 1ns/100ps
`include "datapath_params.svh"

module data_memory (
    input  logic                                             clock,
    input  logic                                             rst_n,
    input  datapath_pkg::instr_t                             s1_instr,
    input  logic                                             s1_live,
    input  logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_read_data_a,
    input  logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_read_data_b,
    input  datapath_pkg::wb_t                                wb,
    output datapath_pkg::operands_t                          ops,
    output logic [`DP_IO_PORT_COUNT-1:0]                     io_wren_a,
    output logic [`DP_IO_PORT_COUNT-1:0]                     io_wren_b,
    output logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_write_data_a,
    output logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_write_data_b
);

    // Per-side views, index 0 is A and index 1 is B
    datapath_pkg::read_addr_u                         rd_addr [2];
    logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_rd_data [2];

    logic [1:0]                    side_hit;
    logic                          wb_is_io;
    logic                          wb_mem;
    logic                          wb_port;
    logic [`DP_IO_PORT_COUNT-1:0]  port_sel;

    // Stage 2 control carried beside the RAM read
    logic                          s2_live;
    datapath_pkg::alu_op_t         s2_op;
    datapath_pkg::write_addr_t     s2_addr_d;

    assign rd_addr[0]    = s1_instr.addr_a;
    assign rd_addr[1]    = s1_instr.addr_b;
    assign io_rd_data[0] = io_read_data_a;
    assign io_rd_data[1] = io_read_data_b;

    // ------------------------------
    // Write-back decode
    // ------------------------------

    assign side_hit = {wb.addr_d.side, !wb.addr_d.side};
    assign wb_is_io = (wb.addr_d.addr.io.tag == `DP_IO_TAG);
    assign wb_mem   = wb.en && !wb_is_io;
    assign wb_port  = wb.en && wb_is_io;

    always_comb begin
        port_sel = '0;
        port_sel[wb.addr_d.addr.io.port] = 1'b1;
    end

    // ------------------------------
    // RAM and port read per side
    // ------------------------------

    for (genvar s = 0; s < 2; s++) begin : g_side
        logic [`DP_WORD_WIDTH-1:0]    ram [`DP_MEM_DEPTH];
        logic [`DP_WORD_WIDTH-1:0]    mem_q;
        logic [`DP_WORD_WIDTH-1:0]    port_q;
        logic                         is_io_q;
        logic [`DP_WORD_WIDTH-1:0]    operand;
        logic [`DP_IO_PORT_COUNT-1:0] port_wren;

        // Write lands on the edge after the result register, read returns old data
        always_ff @(posedge clock) begin
            if (wb_mem && side_hit[s]) begin
                ram[wb.addr_d.addr.mem_index] <= wb.data;
            end
            mem_q   <= ram[rd_addr[s].mem_index];
            port_q  <= io_rd_data[s][rd_addr[s].io.port];
            is_io_q <= (rd_addr[s].io.tag == `DP_IO_TAG);
        end

        assign operand   = is_io_q ? port_q : mem_q;
        assign port_wren = (wb_port && side_hit[s]) ? port_sel : '0;
    end

    // ------------------------------
    // Stage 2 and 3 registers
    // ------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s2_live <= 1'b0;
        end else begin
            s2_live <= s1_live;
        end
    end

    always_ff @(posedge clock) begin
        s2_op     <= s1_instr.op;
        s2_addr_d <= s1_instr.addr_d;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ops <= '0;
        end else begin
            ops.live   <= s2_live;
            ops.op     <= s2_op;
            ops.a      <= g_side[0].operand;
            ops.b      <= g_side[1].operand;
            ops.addr_d <= s2_addr_d;
        end
    end

    // ------------------------------
    // I/O write ports
    // ------------------------------

    // Every port of a side sees the result, wren picks the one that takes it
    assign io_write_data_a = {`DP_IO_PORT_COUNT{wb.data}};
    assign io_write_data_b = {`DP_IO_PORT_COUNT{wb.data}};
    assign io_wren_a       = g_side[0].port_wren;
    assign io_wren_b       = g_side[1].port_wren;

endmodule

//--- logic/triadic_alu.sv
// ALU operation decode, result and carry, and the write-back register
`timescale 1ns/100ps
`include "datapath_params.svh"

module triadic_alu (
    input  logic                    clock,
    input  logic                    rst_n,
    input  datapath_pkg::operands_t ops,
    output datapath_pkg::wb_t       wb
);

    logic                      is_sub;
    logic [`DP_WORD_WIDTH-1:0] b_in;
    logic [`DP_WORD_WIDTH:0]   sum;
    logic [`DP_WORD_WIDTH-1:0] result;
    logic                      carry;

    // ------------------------------
    // Shared adder
    // ------------------------------

    // Subtract as a plus inverted b plus one, carry high means no borrow
    assign is_sub = (ops.op == datapath_pkg::sub);
    assign b_in   = is_sub ? ~ops.b : ops.b;
    assign sum    = {1'b0, ops.a} + {1'b0, b_in} + {{`DP_WORD_WIDTH{1'b0}}, is_sub};

    always_comb begin
        result = ops.a;
        carry  = 1'b0;
        case (ops.op)
            datapath_pkg::pass_b: result = ops.b;
            datapath_pkg::add,
            datapath_pkg::sub: begin
                result = sum[`DP_WORD_WIDTH-1:0];
                carry  = sum[`DP_WORD_WIDTH];
            end
            datapath_pkg::op_and: result = ops.a & ops.b;
            datapath_pkg::op_or:  result = ops.a | ops.b;
            datapath_pkg::op_xor: result = ops.a ^ ops.b;
            // pass_a and the spare code 7
            default: result = ops.a;
        endcase
    end

    // ------------------------------
    // Result register
    // ------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.en     <= ops.live;
            wb.addr_d <= ops.addr_d;
            wb.data   <= result;
            wb.carry  <= carry;
        end
    end

endmodule

//--- logic/datapath_top.sv
// Datapath top level joining I/O predication, data memory and ALU
`timescale 1ns/100ps
`include "datapath_params.svh"

module datapath_top (
    input  logic                                             clock,
    input  logic                                             rst_n,

    // Instruction stream from the control path
    input  datapath_pkg::instr_t                             instr,
    input  logic                                             cancel,

    // Empty/full bits of the I/O ports
    input  logic [`DP_IO_PORT_COUNT-1:0]                     io_read_ef_a,
    input  logic [`DP_IO_PORT_COUNT-1:0]                     io_read_ef_b,
    input  logic [`DP_IO_PORT_COUNT-1:0]                     io_write_ef_a,
    input  logic [`DP_IO_PORT_COUNT-1:0]                     io_write_ef_b,

    input  logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_read_data_a,
    input  logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_read_data_b,

    output logic                                             io_ready,
    output logic [`DP_IO_PORT_COUNT-1:0]                     io_rden_a,
    output logic [`DP_IO_PORT_COUNT-1:0]                     io_rden_b,
    output logic [`DP_IO_PORT_COUNT-1:0]                     io_wren_a,
    output logic [`DP_IO_PORT_COUNT-1:0]                     io_wren_b,
    output logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_write_data_a,
    output logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_write_data_b,

    // Single write-back path
    output datapath_pkg::wb_t                                wb
);

    datapath_pkg::instr_t    s1_instr;
    logic                    s1_live;
    datapath_pkg::operands_t ops;

    // Stage 1, predication on the empty/full bits
    io_predication u_pred (
        .clock         (clock),
        .rst_n         (rst_n),
        .instr         (instr),
        .cancel        (cancel),
        .io_read_ef_a  (io_read_ef_a),
        .io_read_ef_b  (io_read_ef_b),
        .io_write_ef_a (io_write_ef_a),
        .io_write_ef_b (io_write_ef_b),
        .s1_instr      (s1_instr),
        .s1_live       (s1_live),
        .io_ready      (io_ready),
        .io_rden_a     (io_rden_a),
        .io_rden_b     (io_rden_b)
    );

    // Stages 2 and 3, memory read and operand select
    data_memory u_mem (
        .clock           (clock),
        .rst_n           (rst_n),
        .s1_instr        (s1_instr),
        .s1_live         (s1_live),
        .io_read_data_a  (io_read_data_a),
        .io_read_data_b  (io_read_data_b),
        .wb              (wb),
        .ops             (ops),
        .io_wren_a       (io_wren_a),
        .io_wren_b       (io_wren_b),
        .io_write_data_a (io_write_data_a),
        .io_write_data_b (io_write_data_b)
    );

    // Stage 4, result register
    triadic_alu u_alu (
        .clock (clock),
        .rst_n (rst_n),
        .ops   (ops),
        .wb    (wb)
    );

endmodule

//--- verif/datapath_tb_cases.svh
// Stimulus table with expected ready and live results, and the task that fills it
`ifndef DATAPATH_TB_CASES_SVH
`define DATAPATH_TB_CASES_SVH

// ------------------------------
// Table entry
// ------------------------------

typedef struct packed {
    datapath_pkg::instr_t         instr;
    logic                         cancel;
    logic [`DP_IO_PORT_COUNT-1:0] rd_ef_a;
    logic [`DP_IO_PORT_COUNT-1:0] rd_ef_b;
    logic [`DP_IO_PORT_COUNT-1:0] wr_ef_a;
    logic [`DP_IO_PORT_COUNT-1:0] wr_ef_b;
    logic [`DP_WORD_WIDTH-1:0]    word_a;
    logic [`DP_WORD_WIDTH-1:0]    word_b;
    logic                         exp_ready;
    logic                         exp_live;
    logic [3:0]                   gap;
} tb_case_t;

localparam int N_CASES = 19;

// I/O port addresses on either side
localparam logic [5:0] P0 = 6'd60;
localparam logic [5:0] P1 = 6'd61;
localparam logic [5:0] P2 = 6'd62;
localparam logic [5:0] P3 = 6'd63;

tb_case_t cases [N_CASES];

// ef nibbles in order read A, read B, write A, write B; exp is {ready, live}
function automatic tb_case_t make_case(input datapath_pkg::alu_op_t op,
        input logic [5:0] addr_a, input logic [5:0] addr_b, input logic side,
        input logic [5:0] addr_d, input logic cancel, input logic [15:0] ef,
        input logic [1:0] exp);
    tb_case_t c;
    c = '0;
    c.instr.op                  = op;
    c.instr.addr_a.mem_index    = addr_a;
    c.instr.addr_b.mem_index    = addr_b;
    c.instr.addr_d.side         = side;
    c.instr.addr_d.addr.mem_index = addr_d;
    c.cancel    = cancel;
    c.rd_ef_a   = ef[15:12];
    c.rd_ef_b   = ef[11:8];
    c.wr_ef_a   = ef[7:4];
    c.wr_ef_b   = ef[3:0];
    c.exp_ready = exp[1];
    c.exp_live  = exp[0];
    c.gap       = 4'd4;
    return c;
endfunction

task automatic load_cases;
    logic [31:0] rnd;
    // Load from A port 1 into memory A word 5, then copy it out to B port 2
    cases[0]  = make_case(datapath_pkg::pass_a, P1, 6'd0, 1'b0, 6'd5, 1'b0, 16'h2000, 2'b11);
    cases[1]  = make_case(datapath_pkg::pass_a, 6'd5, 6'd0, 1'b1, P2, 1'b0, 16'h0004, 2'b11);
    // Every ALU code, port to port
    cases[2]  = make_case(datapath_pkg::pass_a, P0, P3, 1'b0, P0, 1'b0, 16'hFFFF, 2'b11);
    cases[3]  = make_case(datapath_pkg::pass_b, P0, P3, 1'b0, P1, 1'b0, 16'hFFFF, 2'b11);
    cases[4]  = make_case(datapath_pkg::add, P0, P3, 1'b1, P2, 1'b0, 16'hFFFF, 2'b11);
    cases[5]  = make_case(datapath_pkg::sub, P0, P3, 1'b1, P3, 1'b0, 16'hFFFF, 2'b11);
    cases[6]  = make_case(datapath_pkg::op_and, P0, P3, 1'b0, P2, 1'b0, 16'hFFFF, 2'b11);
    cases[7]  = make_case(datapath_pkg::op_or, P0, P3, 1'b1, P0, 1'b0, 16'hFFFF, 2'b11);
    cases[8]  = make_case(datapath_pkg::op_xor, P0, P3, 1'b0, P3, 1'b0, 16'hFFFF, 2'b11);
    cases[9]  = make_case(datapath_pkg::alu_op_t'(3'd7), P0, P3, 1'b1, P1, 1'b0, 16'hFFFF,
                          2'b11);
    // Empty read port, full write port, then cancel with everything ready
    cases[10] = make_case(datapath_pkg::add, P2, 6'd5, 1'b0, 6'd5, 1'b0, 16'hBFFF, 2'b00);
    cases[11] = make_case(datapath_pkg::pass_a, P0, P0, 1'b1, P1, 1'b0, 16'hFFFD, 2'b00);
    cases[12] = make_case(datapath_pkg::pass_a, P0, P0, 1'b0, 6'd5, 1'b1, 16'hFFFF, 2'b10);
    // Word 5 must still hold the first load
    cases[13] = make_case(datapath_pkg::pass_a, 6'd5, 6'd0, 1'b1, P0, 1'b0, 16'hFFFF, 2'b11);
    // Back-to-back burst of four, then a readback of its memory writes
    cases[14] = make_case(datapath_pkg::pass_b, P0, P2, 1'b1, 6'd9, 1'b0, 16'hFFFF, 2'b11);
    cases[15] = make_case(datapath_pkg::op_xor, P1, P1, 1'b0, P2, 1'b0, 16'hFFFF, 2'b11);
    cases[16] = make_case(datapath_pkg::sub, P3, P0, 1'b0, 6'd10, 1'b0, 16'hFFFF, 2'b11);
    cases[17] = make_case(datapath_pkg::op_or, P2, P3, 1'b1, P3, 1'b0, 16'hFFFF, 2'b11);
    cases[18] = make_case(datapath_pkg::add, 6'd10, 6'd9, 1'b1, P1, 1'b0, 16'hFFFF, 2'b11);
    cases[14].gap = 4'd0;
    cases[15].gap = 4'd0;
    cases[16].gap = 4'd0;

    for (int i = 0; i < N_CASES; i++) begin
        rnd = $random(seed);
        cases[i].word_a = rnd[15:0];
        rnd = $random(seed);
        cases[i].word_b = rnd[15:0];
    end
endtask

`endif

//--- verif/datapath_tb.sv
// Datapath testbench with clock and reset, stimulus table loop, compare tasks, port model, watchdog
`timescale 1ns/100ps
`include "datapath_params.svh"

module datapath_tb;

    logic                                             clock;
    logic                                             rst_n;
    datapath_pkg::instr_t                             instr;
    logic                                             cancel;
    logic [`DP_IO_PORT_COUNT-1:0]                     io_read_ef_a;
    logic [`DP_IO_PORT_COUNT-1:0]                     io_read_ef_b;
    logic [`DP_IO_PORT_COUNT-1:0]                     io_write_ef_a;
    logic [`DP_IO_PORT_COUNT-1:0]                     io_write_ef_b;
    logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_read_data_a;
    logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_read_data_b;
    logic                                             io_ready;
    logic [`DP_IO_PORT_COUNT-1:0]                     io_rden_a;
    logic [`DP_IO_PORT_COUNT-1:0]                     io_rden_b;
    logic [`DP_IO_PORT_COUNT-1:0]                     io_wren_a;
    logic [`DP_IO_PORT_COUNT-1:0]                     io_wren_b;
    logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_write_data_a;
    logic [`DP_IO_PORT_COUNT-1:0][`DP_WORD_WIDTH-1:0] io_write_data_b;
    datapath_pkg::wb_t                                wb;

    integer seed = 32'h639e9d78;

    `include "datapath_tb_cases.svh"

    localparam int WATCHDOG_NS = N_CASES * 8 * 8 * 2;

    // Reference model state
    datapath_pkg::wb_t         exp_wb [N_CASES];
    logic [`DP_WORD_WIDTH-1:0] mem_a [`DP_MEM_DEPTH];
    logic [`DP_WORD_WIDTH-1:0] mem_b [`DP_MEM_DEPTH];

    datapath_top dut (.*);

    always #4 clock = ~clock;

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_wb(input string name, input datapath_pkg::wb_t actual,
                            input datapath_pkg::wb_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_word(input string name, input logic [`DP_WORD_WIDTH-1:0] actual,
                              input logic [`DP_WORD_WIDTH-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_flags(input string name, input logic [`DP_IO_PORT_COUNT-1:0] actual,
                               input logic [`DP_IO_PORT_COUNT-1:0] expected);
        for (int p = 0; p < `DP_IO_PORT_COUNT; p++) begin
            check_bit($sformatf("%s[%0d]", name, p), actual[p], expected[p]);
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    // Port model, each port of a side shows the entry word with its own pattern
    function automatic logic [15:0] port_value(input logic [15:0] base, input logic [1:0] port);
        return base ^ (16'h1111 * {14'd0, port});
    endfunction

    function automatic logic is_io(input datapath_pkg::read_addr_u addr);
        return addr.io.tag == `DP_IO_TAG;
    endfunction

    function automatic logic [`DP_IO_PORT_COUNT-1:0] pop_mask(input logic en,
                                                            input datapath_pkg::read_addr_u addr);
        logic [`DP_IO_PORT_COUNT-1:0] mask;
        mask = '0;
        if (en) mask[addr.io.port] = 1'b1;
        return mask;
    endfunction

    function automatic logic [15:0] operand_value(input datapath_pkg::read_addr_u addr,
                                                  input logic side, input logic [15:0] base);
        if (is_io(addr)) return port_value(base, addr.io.port);
        return side ? mem_b[addr.mem_index] : mem_a[addr.mem_index];
    endfunction

    // Carry on top, sub carry high means no borrow
    function automatic logic [16:0] alu_model(input datapath_pkg::alu_op_t op,
                                              input logic [15:0] a, input logic [15:0] b);
        case (op)
            datapath_pkg::pass_b: return {1'b0, b};
            datapath_pkg::add:    return {1'b0, a} + {1'b0, b};
            datapath_pkg::sub:    return {1'b0, a} + {1'b0, ~b} + 17'd1;
            datapath_pkg::op_and: return {1'b0, a & b};
            datapath_pkg::op_or:  return {1'b0, a | b};
            datapath_pkg::op_xor: return {1'b0, a ^ b};
            default:              return {1'b0, a};
        endcase
    endfunction

    // ------------------------------
    // Drive and check per pipeline slot
    // ------------------------------

    // A negative index is an idle slot with cancel high
    task automatic issue_entry(input int idx);
        datapath_pkg::instr_t ins;
        logic [16:0]          res;
        if (idx < 0) begin
            instr  = '0;
            cancel = 1'b1;
        end else begin
            ins           = cases[idx].instr;
            instr         = ins;
            cancel        = cases[idx].cancel;
            io_read_ef_a  = cases[idx].rd_ef_a;
            io_read_ef_b  = cases[idx].rd_ef_b;
            io_write_ef_a = cases[idx].wr_ef_a;
            io_write_ef_b = cases[idx].wr_ef_b;
            res = alu_model(ins.op, operand_value(ins.addr_a, 1'b0, cases[idx].word_a),
                            operand_value(ins.addr_b, 1'b1, cases[idx].word_b));
            exp_wb[idx] = '{en: 1'b1, addr_d: ins.addr_d, data: res[15:0], carry: res[16]};
            if (cases[idx].exp_live && !is_io(ins.addr_d.addr)) begin
                if (ins.addr_d.side) mem_b[ins.addr_d.addr.mem_index] = res[15:0];
                else mem_a[ins.addr_d.addr.mem_index] = res[15:0];
            end
        end
    endtask

    // Port words must hold at the edge after sampling
    task automatic drive_ports(input int idx);
        for (int p = 0; p < `DP_IO_PORT_COUNT; p++) begin
            io_read_data_a[p] = port_value(cases[idx].word_a, 2'(p));
            io_read_data_b[p] = port_value(cases[idx].word_b, 2'(p));
        end
    endtask

    task automatic check_stage1(input int idx);
        logic                 live;
        datapath_pkg::instr_t ins;
        live = 1'b0;
        ins  = '0;
        if (idx >= 0) begin
            live = cases[idx].exp_live;
            ins  = cases[idx].instr;
            check_bit("io_ready", io_ready, cases[idx].exp_ready);
        end
        check_flags("io_rden_a", io_rden_a, pop_mask(live && is_io(ins.addr_a), ins.addr_a));
        check_flags("io_rden_b", io_rden_b, pop_mask(live && is_io(ins.addr_b), ins.addr_b));
    endtask

    task automatic check_result(input int idx);
        logic                         live;
        datapath_pkg::write_addr_t    d;
        logic [`DP_IO_PORT_COUNT-1:0] wren;
        live = 1'b0;
        d    = '0;
        if (idx >= 0) begin
            live = cases[idx].exp_live;
            d    = cases[idx].instr.addr_d;
        end
        wren = pop_mask(live && is_io(d.addr), d.addr);
        if (live) check_wb("wb", wb, exp_wb[idx]);
        else check_bit("wb.en", wb.en, 1'b0);
        check_flags("io_wren_a", io_wren_a, d.side ? '0 : wren);
        check_flags("io_wren_b", io_wren_b, d.side ? wren : '0);
        // Every port of the written side carries the result
        if (wren != '0) begin
            for (int p = 0; p < `DP_IO_PORT_COUNT; p++) begin
                check_word($sformatf("io_write_data_%s[%0d]", d.side ? "b" : "a", p),
                           d.side ? io_write_data_b[p] : io_write_data_a[p],
                           exp_wb[idx].data);
            end
        end
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------

    initial begin
        int sched [$];
        clock          = 1'b0;
        rst_n          = 1'b0;
        instr          = '0;
        cancel         = 1'b1;
        io_read_ef_a   = '0;
        io_read_ef_b   = '0;
        io_write_ef_a  = '0;
        io_write_ef_b  = '0;
        io_read_data_a = '0;
        io_read_data_b = '0;
        load_cases();
        for (int i = 0; i < N_CASES; i++) begin
            sched.push_back(i);
            for (int g = 0; g < int'(cases[i].gap); g++) sched.push_back(-1);
        end
        // Drain the pipeline
        repeat (5) sched.push_back(-1);
        repeat (5) @(negedge clock);
        rst_n = 1'b1;
        for (int c = 0; c < sched.size(); c++) begin
            @(negedge clock);
            if (c >= 1) begin
                check_stage1(sched[c-1]);
                if (sched[c-1] >= 0) drive_ports(sched[c-1]);
            end
            if (c >= `DP_WB_LATENCY) check_result(sched[c-`DP_WB_LATENCY]);
            issue_entry(sched[c]);
        end
        $display("Everything OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout, the test sequence did not reach its end in time");
    end

endmodule

//--- filelist.f
+incdir+logic
+incdir+verif
logic/datapath_pkg.sv
logic/io_predication.sv
logic/data_memory.sv
logic/triadic_alu.sv
logic/datapath_top.sv
verif/datapath_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the datapath testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f filelist.f \
    --top-module datapath_tb -Mdir obj_dir -o datapath_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build returned status $build_status"
    exit "$build_status"
fi

./obj_dir/datapath_sim
run_status=$?
if [ "$run_status" -ne 0 ]; then
    echo "Simulation returned status $run_status"
    exit "$run_status"
fi

exit 0
